// ==== common/ooo_pkg.sv ====
/*
 sizes and types shared by the single-thread out-of-order back end
 changing a size here resizes the whole core
 TAG_W and RS_IDX_W must stay log2 of PRF_SIZE and RS_SIZE
 the multiplier datapath is split for exactly three stages
*/
package ooo_pkg;

	localparam int XLEN        = 32;                // data width
	localparam int PRF_SIZE    = 32;                // physical registers
	localparam int TAG_W       = $clog2(PRF_SIZE);  // tag bits, 5
	localparam int RS_SIZE     = 8;                 // station entries
	localparam int RS_IDX_W    = $clog2(RS_SIZE);   // station entry index
	localparam int MULT_STAGES = 3;                 // multiplier depth

	// operation select, MUL goes to the multiplier and the rest to the alu
	typedef enum logic [2:0] {
		ALU_ADD = 3'd0,
		ALU_SUB = 3'd1,
		ALU_AND = 3'd2,
		ALU_OR  = 3'd3,
		ALU_XOR = 3'd4,
		ALU_SLL = 3'd5,
		ALU_MUL = 3'd6
	} alu_func_t;

	typedef logic [TAG_W-1:0] tag_t;   // physical register tag
	typedef logic [XLEN-1:0]  data_t;  // data word

	// waiting form of an operand, tag in the low bits
	typedef struct packed {
		logic [XLEN-TAG_W-1:0] zero;     // kept zero while waiting
		tag_t                  tag;      // producer tag to watch on the cdb
	} operand_wait_t;

	// one station operand word, a value once ready and a tag before that
	typedef union packed {
		data_t         value;           // valid when the ready bit is set
		operand_wait_t waiting;         // valid while the ready bit is clear
	} operand_u;

endpackage

// ==== hdl/prf.sv ====
/*
 physical register file with one ready bit per tag
 reads are combinational and bypass a same-cycle cdb broadcast
 after reset every register reads ready with value zero
*/
`timescale 1ns/10ps

module prf (
	input  logic           clock,
	input  logic           rst,
	input  logic           dispatch_valid,
	input  ooo_pkg::tag_t  src_a,
	input  ooo_pkg::tag_t  src_b,
	input  ooo_pkg::tag_t  dest,
	input  logic           cdb_valid,
	input  ooo_pkg::tag_t  cdb_tag,
	input  ooo_pkg::data_t cdb_value,
	output logic           src_a_ready,
	output logic           src_b_ready,
	output ooo_pkg::data_t src_a_value,
	output ooo_pkg::data_t src_b_value
);
	import ooo_pkg::*;

	data_t               regs [PRF_SIZE];   // register values
	logic [PRF_SIZE-1:0] ready;             // value written since last dispatch
	logic                hit_a;             // cdb carries src a this cycle
	logic                hit_b;

	assign hit_a = cdb_valid && cdb_tag == src_a;
	assign hit_b = cdb_valid && cdb_tag == src_b;

	assign src_a_ready = ready[src_a] || hit_a;
	assign src_b_ready = ready[src_b] || hit_b;
	assign src_a_value = hit_a ? cdb_value : regs[src_a];
	assign src_b_value = hit_b ? cdb_value : regs[src_b];

	always_ff @(posedge clock) begin
		if (rst) begin
			ready <= '1;
			for (int i = 0; i < PRF_SIZE; i++)
				regs[i] <= '0;                      // unwritten tags read zero
		end else begin
			if (cdb_valid) begin
				regs[cdb_tag]  <= cdb_value;
				ready[cdb_tag] <= 1'b1;
			end
			if (dispatch_valid)
				ready[dest] <= 1'b0;                // new producer in flight
		end
	end

	// a broadcast only ever completes a tag that dispatch made busy
	a_cdb_not_ready: assert property (@(posedge clock) disable iff (rst)
		cdb_valid |-> !ready[cdb_tag]);

endmodule

// ==== rs/rs.sv ====
/*
 reservation station, operands held by value or by producer tag
 wakeup comes only from the cdb, same-cycle bypass is done in prf
 lowest ready entry issues first, one per unit per cycle
 dispatch_valid must stay low while full
*/
`timescale 1ns/10ps

module rs (
	input  logic               clock,
	input  logic               rst,
	input  logic               dispatch_valid,
	input  ooo_pkg::alu_func_t dispatch_func,
	input  ooo_pkg::tag_t      dispatch_dest,
	input  logic               src_a_ready,
	input  logic               src_b_ready,
	input  ooo_pkg::data_t     src_a_value,
	input  ooo_pkg::data_t     src_b_value,
	input  ooo_pkg::tag_t      dispatch_src_a,
	input  ooo_pkg::tag_t      dispatch_src_b,
	input  logic               dispatch_use_imm,
	input  ooo_pkg::data_t     dispatch_imm,
	input  logic               cdb_valid,
	input  ooo_pkg::tag_t      cdb_tag,
	input  ooo_pkg::data_t     cdb_value,
	input  logic               alu_free,
	input  logic               mult_free,
	output logic               full,
	output logic               alu_issue,
	output ooo_pkg::alu_func_t alu_func,
	output ooo_pkg::data_t     alu_opa,
	output ooo_pkg::data_t     alu_opb,
	output ooo_pkg::tag_t      alu_dest,
	output logic               mult_issue,
	output ooo_pkg::data_t     mult_opa,
	output ooo_pkg::data_t     mult_opb,
	output ooo_pkg::tag_t      mult_dest
);
	import ooo_pkg::*;

	logic [RS_SIZE-1:0]  busy;                 // entry occupied
	logic [RS_SIZE-1:0]  opa_rdy;              // opa holds a value
	logic [RS_SIZE-1:0]  opb_rdy;
	operand_u            opa [RS_SIZE];
	operand_u            opb [RS_SIZE];
	alu_func_t           func [RS_SIZE];
	tag_t                dest [RS_SIZE];

	logic [RS_SIZE-1:0]  ready_alu;            // all operands in, alu op
	logic [RS_SIZE-1:0]  ready_mult;           // all operands in, multiply
	logic [RS_IDX_W-1:0] alloc_idx;            // lowest empty slot
	logic [RS_IDX_W-1:0] alu_idx;
	logic [RS_IDX_W-1:0] mult_idx;
	logic                alu_found;
	logic                mult_found;
	operand_u            new_opa;
	operand_u            new_opb;

	assign full = &busy;

	//////////////////////////////////////////////////////////////////////
	// selection

	always_comb begin
		alloc_idx  = '0;
		alu_idx    = '0;
		mult_idx   = '0;
		alu_found  = 1'b0;
		mult_found = 1'b0;
		for (int i = RS_SIZE - 1; i >= 0; i--) begin   // walk down, lowest hit stays
			ready_alu[i]  = busy[i] && opa_rdy[i] && opb_rdy[i] && func[i] != ALU_MUL;
			ready_mult[i] = busy[i] && opa_rdy[i] && opb_rdy[i] && func[i] == ALU_MUL;
			if (!busy[i])
				alloc_idx = RS_IDX_W'(i);
			if (ready_alu[i]) begin
				alu_idx   = RS_IDX_W'(i);
				alu_found = 1'b1;
			end
			if (ready_mult[i]) begin
				mult_idx   = RS_IDX_W'(i);
				mult_found = 1'b1;
			end
		end
	end

	assign alu_issue  = alu_found && alu_free;
	assign alu_func   = func[alu_idx];
	assign alu_opa    = opa[alu_idx].value;
	assign alu_opb    = opb[alu_idx].value;
	assign alu_dest   = dest[alu_idx];
	assign mult_issue = mult_found && mult_free;
	assign mult_opa   = opa[mult_idx].value;
	assign mult_opb   = opb[mult_idx].value;
	assign mult_dest  = dest[mult_idx];

	// capture form of the incoming operands
	always_comb begin
		new_opa = '0;
		new_opb = '0;
		if (src_a_ready)
			new_opa.value = src_a_value;
		else
			new_opa.waiting.tag = dispatch_src_a;   // upper bits stay zero
		if (dispatch_use_imm)
			new_opb.value = dispatch_imm;           // immediate replaces src b
		else if (src_b_ready)
			new_opb.value = src_b_value;
		else
			new_opb.waiting.tag = dispatch_src_b;
	end

	//////////////////////////////////////////////////////////////////////
	// entry state

	always_ff @(posedge clock) begin
		if (rst) begin
			busy <= '0;
		end else begin
			for (int i = 0; i < RS_SIZE; i++) begin
				if ((alu_issue && alu_idx == RS_IDX_W'(i)) ||
						(mult_issue && mult_idx == RS_IDX_W'(i)))
					busy[i] <= 1'b0;                  // freed at the issue edge
			end
			if (dispatch_valid)
				busy[alloc_idx] <= 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		for (int i = 0; i < RS_SIZE; i++) begin
			if (cdb_valid && !opa_rdy[i] && opa[i].waiting.tag == cdb_tag) begin
				opa[i].value <= cdb_value;            // wakeup overwrites the tag
				opa_rdy[i]   <= 1'b1;
			end
			if (cdb_valid && !opb_rdy[i] && opb[i].waiting.tag == cdb_tag) begin
				opb[i].value <= cdb_value;
				opb_rdy[i]   <= 1'b1;
			end
		end
		if (dispatch_valid) begin                 // slot is empty, no wakeup clash
			opa[alloc_idx]     <= new_opa;
			opb[alloc_idx]     <= new_opb;
			opa_rdy[alloc_idx] <= src_a_ready;
			opb_rdy[alloc_idx] <= dispatch_use_imm || src_b_ready;
			func[alloc_idx]    <= dispatch_func;
			dest[alloc_idx]    <= dispatch_dest;
		end
	end

	a_no_dispatch_full: assert property (@(posedge clock) disable iff (rst)
		dispatch_valid |-> !full);
	// an issued entry carries captured values, never a stale or empty slot
	a_alu_issue_known: assert property (@(posedge clock) disable iff (rst)
		alu_issue |-> !$isunknown({alu_opa, alu_opb, alu_dest}));
	a_mult_issue_known: assert property (@(posedge clock) disable iff (rst)
		mult_issue |-> !$isunknown({mult_opa, mult_opb, mult_dest}));

endmodule

// ==== hdl/alu_unit.sv ====
/*
 one-cycle integer unit with a single output register
 the result is held until the cdb grant, issue is refused meanwhile
 SLL shifts by the low 5 bits of opb
*/
`timescale 1ns/10ps

module alu_unit (
	input  logic               clock,
	input  logic               rst,
	input  logic               issue,
	input  ooo_pkg::alu_func_t func,
	input  ooo_pkg::data_t     opa,
	input  ooo_pkg::data_t     opb,
	input  ooo_pkg::tag_t      dest,
	input  logic               grant,
	output logic               free,
	output logic               result_ready,
	output ooo_pkg::tag_t      result_tag,
	output ooo_pkg::data_t     result_value
);
	import ooo_pkg::*;

	data_t alu_result;   // combinational result of the issued op

	always_comb begin
		case (func)
			ALU_ADD: alu_result = opa + opb;
			ALU_SUB: alu_result = opa - opb;
			ALU_AND: alu_result = opa & opb;
			ALU_OR:  alu_result = opa | opb;
			ALU_XOR: alu_result = opa ^ opb;
			ALU_SLL: alu_result = opa << opb[4:0];
			default: alu_result = '0;          // MUL never reaches this unit
		endcase
	end

	assign free = !result_ready || grant;   // empty, or emptied this edge

	always_ff @(posedge clock) begin
		if (rst)
			result_ready <= 1'b0;
		else if (issue)
			result_ready <= 1'b1;
		else if (grant)
			result_ready <= 1'b0;
	end

	always_ff @(posedge clock) begin
		if (issue) begin
			result_tag   <= dest;
			result_value <= alu_result;
		end
	end

endmodule

// ==== hdl/mult_unit.sv ====
/*
 three-stage multiplier, keeps the low XLEN bits of the product
 stage 1 forms half-word partial products, stage 2 folds the cross terms
 stage 3 adds them up; the whole pipe stalls on an ungranted result
*/
`timescale 1ns/10ps

module mult_unit (
	input  logic           clock,
	input  logic           rst,
	input  logic           issue,
	input  ooo_pkg::data_t opa,
	input  ooo_pkg::data_t opb,
	input  ooo_pkg::tag_t  dest,
	input  logic           grant,
	output logic           free,
	output logic           result_ready,
	output ooo_pkg::tag_t  result_tag,
	output ooo_pkg::data_t result_value
);
	import ooo_pkg::*;

	logic [MULT_STAGES-1:0] stage_valid;        // one valid bit per stage
	tag_t                   stage_tag [MULT_STAGES];
	data_t                  ll_s1;               // lo x lo
	logic [XLEN/2-1:0]      lh_s1;               // lo a x hi b, low half
	logic [XLEN/2-1:0]      hl_s1;               // hi a x lo b, low half
	data_t                  ll_s2;
	logic [XLEN/2-1:0]      cross_s2;            // cross terms, only low half counts
	data_t                  prod_s3;
	logic                   advance;

	assign result_ready = stage_valid[MULT_STAGES-1];
	assign result_tag   = stage_tag[MULT_STAGES-1];
	assign result_value = prod_s3;
	assign advance      = !result_ready || grant;
	assign free         = advance;

	always_ff @(posedge clock) begin
		if (rst)
			stage_valid <= '0;
		else if (advance)
			stage_valid <= {stage_valid[MULT_STAGES-2:0], issue};
	end

	always_ff @(posedge clock) begin
		if (advance) begin
			stage_tag[0] <= dest;
			for (int i = 1; i < MULT_STAGES; i++)
				stage_tag[i] <= stage_tag[i-1];
			ll_s1    <= opa[XLEN/2-1:0] * opb[XLEN/2-1:0];
			lh_s1    <= opa[XLEN/2-1:0] * opb[XLEN-1:XLEN/2];
			hl_s1    <= opa[XLEN-1:XLEN/2] * opb[XLEN/2-1:0];
			ll_s2    <= ll_s1;
			cross_s2 <= lh_s1 + hl_s1;
			prod_s3  <= ll_s2 + {cross_s2, {(XLEN/2){1'b0}}};   // hi x hi drops out
		end
	end

endmodule

// ==== hdl/cdb_arbiter.sv ====
/*
 round-robin grant of the single cdb between the alu and the multiplier
 grant and bus are combinational, the bus follows the grant that cycle
 a unit that is not granted must hold its result until it is
*/
`timescale 1ns/10ps

module cdb_arbiter (
	input  logic           clock,
	input  logic           rst,
	input  logic           alu_ready,
	input  ooo_pkg::tag_t  alu_tag,
	input  ooo_pkg::data_t alu_value,
	input  logic           mult_ready,
	input  ooo_pkg::tag_t  mult_tag,
	input  ooo_pkg::data_t mult_value,
	output logic           alu_grant,
	output logic           mult_grant,
	output logic           cdb_valid,
	output ooo_pkg::tag_t  cdb_tag,
	output ooo_pkg::data_t cdb_value
);
	logic last_mult;   // multiplier won the last grant

	// on a tie the unit not granted last time wins
	assign alu_grant  = alu_ready && (!mult_ready || last_mult);
	assign mult_grant = mult_ready && (!alu_ready || !last_mult);

	assign cdb_valid = alu_grant || mult_grant;
	assign cdb_tag   = mult_grant ? mult_tag : alu_tag;
	assign cdb_value = mult_grant ? mult_value : alu_value;

	always_ff @(posedge clock) begin
		if (rst)
			last_mult <= 1'b0;               // multiplier favoured first tie after reset
		else if (cdb_valid)
			last_mult <= mult_grant;
	end

	// a unit that loses the bus wins it the very next cycle
	a_rr_mult_next: assert property (@(posedge clock) disable iff (rst)
		alu_grant && mult_ready |=> mult_grant);
	a_rr_alu_next: assert property (@(posedge clock) disable iff (rst)
		mult_grant && alu_ready |=> alu_grant);
	// a waiting result stays put until it wins the bus
	a_alu_hold: assert property (@(posedge clock) disable iff (rst)
		alu_ready && !alu_grant |=> alu_ready && $stable(alu_tag) && $stable(alu_value));
	a_mult_hold: assert property (@(posedge clock) disable iff (rst)
		mult_ready && !mult_grant |=> mult_ready && $stable(mult_tag) && $stable(mult_value));

endmodule

// ==== hdl/ooo_core.sv ====
/*
 back end top: register file, station, alu, multiplier and one cdb
 the caller allocates dest tags and must not dispatch while rs_full
 a dest tag must not be dispatched again before it is broadcast
*/
`timescale 1ns/10ps

module ooo_core (
	input  logic               clock,
	input  logic               rst,
	input  logic               dispatch_valid,
	input  ooo_pkg::alu_func_t dispatch_func,
	input  ooo_pkg::tag_t      dispatch_src_a,
	input  ooo_pkg::tag_t      dispatch_src_b,
	input  logic               dispatch_use_imm,
	input  ooo_pkg::data_t     dispatch_imm,
	input  ooo_pkg::tag_t      dispatch_dest,
	output logic               rs_full,
	output logic               cdb_valid,
	output ooo_pkg::tag_t      cdb_tag,
	output ooo_pkg::data_t     cdb_value
);
	import ooo_pkg::*;

	logic      src_a_ready;     // prf to station
	logic      src_b_ready;
	data_t     src_a_value;
	data_t     src_b_value;
	logic      alu_issue;       // station to alu
	alu_func_t alu_func;
	data_t     alu_opa;
	data_t     alu_opb;
	tag_t      alu_dest;
	logic      mult_issue;      // station to multiplier
	data_t     mult_opa;
	data_t     mult_opb;
	tag_t      mult_dest;
	logic      alu_free;        // units back to station
	logic      mult_free;
	logic      alu_ready;       // units to arbiter
	tag_t      alu_tag;
	data_t     alu_value;
	logic      mult_ready;
	tag_t      mult_tag;
	data_t     mult_value;
	logic      alu_grant;       // arbiter back to units
	logic      mult_grant;

	//////////////////////////////////////////////////////////////////////
	// register file and station

	prf u_prf (
		.clock(clock), .rst(rst),
		.dispatch_valid(dispatch_valid),
		.src_a(dispatch_src_a), .src_b(dispatch_src_b), .dest(dispatch_dest),
		.cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_value(cdb_value),
		.src_a_ready(src_a_ready), .src_b_ready(src_b_ready),
		.src_a_value(src_a_value), .src_b_value(src_b_value)
	);

	rs u_rs (
		.clock(clock), .rst(rst),
		.dispatch_valid(dispatch_valid), .dispatch_func(dispatch_func),
		.dispatch_dest(dispatch_dest),
		.src_a_ready(src_a_ready), .src_b_ready(src_b_ready),
		.src_a_value(src_a_value), .src_b_value(src_b_value),
		.dispatch_src_a(dispatch_src_a), .dispatch_src_b(dispatch_src_b),
		.dispatch_use_imm(dispatch_use_imm), .dispatch_imm(dispatch_imm),
		.cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_value(cdb_value),
		.alu_free(alu_free), .mult_free(mult_free),
		.full(rs_full),
		.alu_issue(alu_issue), .alu_func(alu_func),
		.alu_opa(alu_opa), .alu_opb(alu_opb), .alu_dest(alu_dest),
		.mult_issue(mult_issue),
		.mult_opa(mult_opa), .mult_opb(mult_opb), .mult_dest(mult_dest)
	);

	//////////////////////////////////////////////////////////////////////
	// execution units and the shared bus

	alu_unit u_alu (
		.clock(clock), .rst(rst),
		.issue(alu_issue), .func(alu_func),
		.opa(alu_opa), .opb(alu_opb), .dest(alu_dest), .grant(alu_grant),
		.free(alu_free), .result_ready(alu_ready),
		.result_tag(alu_tag), .result_value(alu_value)
	);

	mult_unit u_mult (
		.clock(clock), .rst(rst),
		.issue(mult_issue),
		.opa(mult_opa), .opb(mult_opb), .dest(mult_dest), .grant(mult_grant),
		.free(mult_free), .result_ready(mult_ready),
		.result_tag(mult_tag), .result_value(mult_value)
	);

	cdb_arbiter u_arb (
		.clock(clock), .rst(rst),
		.alu_ready(alu_ready), .alu_tag(alu_tag), .alu_value(alu_value),
		.mult_ready(mult_ready), .mult_tag(mult_tag), .mult_value(mult_value),
		.alu_grant(alu_grant), .mult_grant(mult_grant),
		.cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_value(cdb_value)
	);

endmodule

// ==== testbench/tb_model.svh ====
/*
 reference model of the back end, included inside tb_ooo_core
 keeps the value each tag will hold and the set of tags in flight
 a tag's value is set at dispatch, since a busy tag is never re-dispatched
*/
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

data_t               model_val [PRF_SIZE];   // value the tag holds or will hold
logic [PRF_SIZE-1:0] busy_tag;               // dispatched, not yet broadcast
int                  busy_count;
int                  errors;
int                  broadcasts;
int                  dispatched;

function automatic data_t expected_result(input alu_func_t f, input data_t a, input data_t b);
	logic [2*XLEN-1:0] product;
	product = a * b;                         // full product, low half is kept
	case (f)
		ALU_ADD: return a + b;
		ALU_SUB: return a - b;
		ALU_AND: return a & b;
		ALU_OR:  return a | b;
		ALU_XOR: return a ^ b;
		ALU_SLL: return a << b[4:0];
		ALU_MUL: return product[XLEN-1:0];
		default: return '0;
	endcase
endfunction

task automatic model_reset();
	for (int i = 0; i < PRF_SIZE; i++)
		model_val[i] = '0;                   // registers read zero after reset
	busy_tag   = '0;
	busy_count = 0;
	errors     = 0;
	broadcasts = 0;
	dispatched = 0;
endtask

task automatic record_dispatch(input alu_func_t f, input tag_t src_a, input tag_t src_b,
		input logic use_imm, input data_t imm, input tag_t dest);
	data_t a;
	data_t b;
	a = model_val[src_a];
	b = use_imm ? imm : model_val[src_b];
	model_val[dest] = expected_result(f, a, b);
	busy_tag[dest]  = 1'b1;
	busy_count++;
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
	if (got !== exp) begin
		errors++;
		$display("mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
	end
endtask

task automatic check_tag(input string name, input tag_t got);
	if ($isunknown(got)) begin
		errors++;
		$display("%s is unknown while cdb_valid is high", name);
	end else if (!busy_tag[got]) begin
		errors++;
		$display("%s broadcast tag 0x%02h that has no instruction in flight", name, got);
	end
endtask

task automatic check_data(input string name, input data_t got, input data_t exp);
	if (got !== exp) begin
		errors++;
		$display("mismatch %s: got 0x%08h expected 0x%08h", name, got, exp);
	end
endtask

// one cdb cycle retires one tag
task automatic retire_broadcast(input tag_t tag, input data_t value);
	broadcasts++;
	check_tag("cdb_tag", tag);
	if (!$isunknown(tag) && busy_tag[tag]) begin
		check_data("cdb_value", value, model_val[tag]);
		busy_tag[tag] = 1'b0;
		busy_count--;
	end
endtask

`endif

// ==== testbench/tb_ooo_core.sv ====
/*
 random test of the back end with a fixed-seed LFSR
 the testbench stands in for rename and picks free dest tags itself
 cdb and rs_full are sampled on the falling edge, before new inputs
*/
`timescale 1ns/10ps

module tb_ooo_core;
	import ooo_pkg::*;

	localparam int N_ZERO          = 8;
	localparam int N_ALU           = 40;
	localparam int N_MUL           = 24;
	localparam int N_CHAIN         = 60;
	localparam int N_BURST         = 64;
	localparam int TOTAL_INSTR     = N_ZERO + N_ALU + N_MUL + N_CHAIN + N_BURST;
	localparam int WATCHDOG_CYCLES = TOTAL_INSTR * 40;
	localparam int M_ZERO  = 0;                // stimulus modes
	localparam int M_ALU   = 1;
	localparam int M_MUL   = 2;
	localparam int M_CHAIN = 3;
	localparam int M_BURST = 4;

	logic      clock;
	logic      rst;
	logic      dispatch_valid;
	alu_func_t dispatch_func;
	tag_t      dispatch_src_a;
	tag_t      dispatch_src_b;
	logic      dispatch_use_imm;
	data_t     dispatch_imm;
	tag_t      dispatch_dest;
	logic      rs_full;
	logic      cdb_valid;
	tag_t      cdb_tag;
	data_t     cdb_value;

	logic [15:0] lfsr;                         // galois state
	tag_t        last_dest;                    // newest producer, feeds chains
	int          full_seen;                    // cycles with rs_full high
	int          tests_run;

	`include "tb_model.svh"

	ooo_core u_ooo_core (
		.clock(clock), .rst(rst),
		.dispatch_valid(dispatch_valid), .dispatch_func(dispatch_func),
		.dispatch_src_a(dispatch_src_a), .dispatch_src_b(dispatch_src_b),
		.dispatch_use_imm(dispatch_use_imm), .dispatch_imm(dispatch_imm),
		.dispatch_dest(dispatch_dest),
		.rs_full(rs_full),
		.cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_value(cdb_value)
	);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;            // 20 ns period
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clock);
		$display("watchdog expired after %0d cycles, results still missing", WATCHDOG_CYCLES);
		$display("Simulation failed");
		$finish;
	end

	//////////////////////////////////////////////////////////////////////
	// random picks

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);   // one step per bit
			r    = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	function automatic logic pick_free_tag(output tag_t t);
		tag_t start;
		start = tag_t'(rand_bits(TAG_W));
		t     = start;
		for (int i = 0; i < PRF_SIZE; i++) begin
			t = start + tag_t'(i);             // probe upward from a random tag
			if (!busy_tag[t])
				return 1'b1;
		end
		return 1'b0;
	endfunction

	function automatic tag_t pick_source(input int mode, input logic is_a);
		tag_t t;
		case (mode)
			M_ZERO:       t = tag_t'(16 + rand_bits(4));   // upper tags, never written yet
			M_ALU, M_MUL: begin
				if (!pick_free_tag(t))
					t = '0;
			end
			M_CHAIN:      t = (is_a && rand_bits(2) != 0) ? last_dest : tag_t'(rand_bits(TAG_W));
			default:      t = is_a ? last_dest : tag_t'(rand_bits(TAG_W));
		endcase
		return t;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// cycle and dispatch

	task automatic next_cycle();
		@(negedge clock);
		dispatch_valid = 1'b0;
		if (cdb_valid)
			retire_broadcast(cdb_tag, cdb_value);
		if (rs_full)
			full_seen++;
	endtask

	task automatic try_dispatch(input int mode, output logic sent);
		tag_t       dest;
		tag_t       src_a;
		tag_t       src_b;
		logic [2:0] f;
		logic       have_dest;
		logic       use_imm;
		data_t      imm;
		sent = 1'b0;
		if (rs_full)
			return;
		if (mode != M_MUL && mode != M_BURST && rand_bits(2) == 0)
			return;                            // idle gap
		if (mode == M_ZERO) begin
			dest      = tag_t'(rand_bits(3));
			have_dest = !busy_tag[dest];
		end else begin
			have_dest = pick_free_tag(dest);
		end
		if (!have_dest)
			return;
		case (mode)
			M_ALU:   f = 3'(rand_bits(3) % 6);
			M_MUL:   f = ALU_MUL;
			M_BURST: f = rand_bits(1) ? ALU_MUL : 3'(rand_bits(3) % 6);
			default: f = 3'(rand_bits(3) % 7);
		endcase
		src_a   = pick_source(mode, 1'b1);
		src_b   = pick_source(mode, 1'b0);
		use_imm = rand_bits(1) != 0;
		imm     = rand_bits(XLEN);
		dispatch_valid   = 1'b1;
		dispatch_func    = alu_func_t'(f);
		dispatch_src_a   = src_a;
		dispatch_src_b   = src_b;
		dispatch_use_imm = use_imm;
		dispatch_imm     = imm;
		dispatch_dest    = dest;
		record_dispatch(alu_func_t'(f), src_a, src_b, use_imm, imm, dest);
		last_dest = dest;
		sent      = 1'b1;
	endtask

	// dispatches count instructions, then drains until nothing is in flight
	task automatic run_test(input string name, input int mode, input int count);
		int   sent_n;
		int   err_start;
		int   full_start;
		logic sent;
		sent_n     = 0;
		err_start  = errors;
		full_start = full_seen;
		while (sent_n < count || busy_count != 0) begin
			next_cycle();
			if (sent_n < count) begin
				try_dispatch(mode, sent);
				if (sent)
					sent_n++;
			end
		end
		if (mode == M_BURST && full_seen == full_start) begin
			errors++;
			$display("rs_full never rose during the burst, the station did not fill");
		end
		dispatched += sent_n;
		tests_run++;
		$display("test %s: %0d dispatched, %0d errors", name, sent_n, errors - err_start);
	endtask

	//////////////////////////////////////////////////////////////////////
	// main sequence

	initial begin
		lfsr             = 16'd42080;
		rst              = 1'b1;
		dispatch_valid   = 1'b0;
		dispatch_func    = ALU_ADD;
		dispatch_src_a   = '0;
		dispatch_src_b   = '0;
		dispatch_use_imm = 1'b0;
		dispatch_imm     = '0;
		dispatch_dest    = '0;
		last_dest        = '0;
		full_seen        = 0;
		tests_run        = 0;
		model_reset();
		repeat (8) @(negedge clock);           // reset held for 8 rising edges
		rst = 1'b0;
		next_cycle();
		check_bit("cdb_valid", cdb_valid, 1'b0);
		check_bit("rs_full", rs_full, 1'b0);
		tests_run++;
		$display("test reset_state: %0d errors", errors);
		run_test("zero_tags", M_ZERO, N_ZERO);
		run_test("alu_indep", M_ALU, N_ALU);
		run_test("mult_b2b", M_MUL, N_MUL);
		run_test("dep_chain", M_CHAIN, N_CHAIN);
		run_test("burst_full", M_BURST, N_BURST);
		if (broadcasts != dispatched) begin
			errors++;
			$display("%0d broadcasts seen for %0d dispatches", broadcasts, dispatched);
		end
		$display("%0d tests, %0d dispatched, %0d broadcasts, %0d errors",
			tests_run, dispatched, broadcasts, errors);
		if (errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// ==== list.f ====
+incdir+testbench
common/ooo_pkg.sv
hdl/prf.sv
rs/rs.sv
hdl/alu_unit.sv
hdl/mult_unit.sv
hdl/cdb_arbiter.sv
hdl/ooo_core.sv
testbench/tb_ooo_core.sv

// ==== Makefile ====
# Verilator build and run of the out-of-order back end testbench

VERILATOR   ?= verilator
TOP         ?= tb_ooo_core
FILE_LIST   ?= list.f
OBJ_DIR     ?= obj_dir
LOG         ?= sim.log
VFLAGS      ?= --timing --assert
BUILD_FLAGS ?= --binary -j 0
FAIL_MSG    ?= Simulation failed
PASS_MSG    ?= Simulation completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(BUILD_FLAGS) $(VFLAGS) -f $(FILE_LIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "FAIL: see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "FAIL: run ended early, see $(LOG)"; exit 1; fi
	@echo "PASS"

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILE_LIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
